// File: include/emu_defines.svh
//////////////////////////////////////////////////////////////////////
// Global widths and sizes for the emulator glue logic
// APB register offsets and the LCD auto-mode hold time
//////////////////////////////////////////////////////////////////////
`ifndef EMU_DEFINES_SVH
`define EMU_DEFINES_SVH

// Menu status word
`define EMU_STATUS_W 64

// APB slave bus
`define EMU_APB_AW 4
`define EMU_APB_DW 32

// Register offsets
`define EMU_REG_STAT_LO 4'h0
`define EMU_REG_STAT_HI 4'h4
`define EMU_REG_SYS     4'h8

// Core loader address width
`define EMU_LDR_AW 20

// Cycles the LCD stays lit after an update in auto mode
`define EMU_LCD_HOLD 200

`endif

// File: rtl/emu_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Configuration types: status word, its field positions,
// info mode encoding and the register map types
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "emu_defines.svh"

package emu_cfg_pkg;

	// Menu status word as written by the host
	typedef logic [`EMU_STATUS_W-1:0] status_t;

	// Field positions inside the status word
	localparam int ST_RESET    = 0;
	localparam int ST_MT32_DIS = 18;
	// Low bit of the two-bit info mode field
	localparam int ST_INFO_LO  = 41;

	typedef enum logic [1:0] {
		INFO_OFF      = 2'd0,
		INFO_MENU     = 2'd1,
		INFO_LCD_ON   = 2'd2,
		INFO_LCD_AUTO = 2'd3
	} info_mode_e;

	// Read-only system register, low bits
	typedef struct packed {
		logic ldr_done;
		logic core_rst_n;
		logic lcd_on;
	} sys_flags_t;

	// APB access phase, first or second cycle
	typedef enum logic {
		ACC_WAIT = 1'b0,
		ACC_DONE = 1'b1
	} acc_state_e;

endpackage

`default_nettype wire

// File: rtl/emu_av_pkg.sv
//////////////////////////////////////////////////////////////////////
// Audio sample and pixel types
//////////////////////////////////////////////////////////////////////
`default_nettype none

package emu_av_pkg;

	// One channel of audio, 16 bits, sums wrap
	typedef logic [15:0] sample_t;

	// 24-bit RGB pixel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

endpackage

`default_nettype wire

// File: rtl/status_regs.sv
//////////////////////////////////////////////////////////////////////
// APB slave with one wait state
// 64-bit menu status word plus a read-only system register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "emu_defines.svh"

module status_regs (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic [`EMU_APB_AW-1:0]   paddr,
	input  logic [`EMU_APB_DW-1:0]   pwdata,
	output logic [`EMU_APB_DW-1:0]   prdata,
	output logic                     pready,
	output logic                     pslverr,
	input  logic [2:0]               sys_flags,
	output emu_cfg_pkg::status_t     status
);

	emu_cfg_pkg::acc_state_e acc_q;
	emu_cfg_pkg::sys_flags_t flags;
	logic                    access;
	logic                    sel_lo;
	logic                    sel_hi;
	logic                    sel_sys;
	logic                    bad;

	assign flags  = sys_flags;
	assign access = psel & penable;

	// Offset decode
	assign sel_lo  = (paddr == `EMU_REG_STAT_LO);
	assign sel_hi  = (paddr == `EMU_REG_STAT_HI);
	assign sel_sys = (paddr == `EMU_REG_SYS);
	// Unmapped, or a write to the read-only register
	assign bad     = ~(sel_lo | sel_hi | sel_sys) | (sel_sys & pwrite);

	// Second access cycle completes the transfer
	assign pready  = access & (acc_q == emu_cfg_pkg::ACC_DONE);
	assign pslverr = pready & bad;

	always_comb begin
		prdata = '0;
		if (sel_lo)
			prdata = status[31:0];
		else if (sel_hi)
			prdata = status[63:32];
		else if (sel_sys)
			prdata = {{(`EMU_APB_DW-3){1'b0}}, flags};
	end

	////////////////////////////////////////////////////////////////////////
	// Access state and register writes
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			acc_q  <= emu_cfg_pkg::ACC_WAIT;
			status <= '0;
		end else begin
			// One wait state, then back to idle on completion
			if (access && acc_q == emu_cfg_pkg::ACC_WAIT)
				acc_q <= emu_cfg_pkg::ACC_DONE;
			else
				acc_q <= emu_cfg_pkg::ACC_WAIT;

			if (pready && pwrite && !bad) begin
				if (sel_lo)
					status[31:0] <= pwdata;
				if (sel_hi)
					status[63:32] <= pwdata;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/sys_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Core reset sequencer
// ROM loader write handshake toward the core
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "emu_defines.svh"

module sys_ctrl (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  emu_cfg_pkg::status_t   status,
	input  logic                   btn_reset,
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  logic [`EMU_LDR_AW-1:0] ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	output logic                   ioctl_wait,
	output logic [`EMU_LDR_AW-1:0] ldr_addr,
	output logic [7:0]             ldr_wdat,
	output logic                   ldr_aen,
	output logic                   ldr_wr,
	input  logic                   ldr_ack,
	output logic                   ldr_done,
	output logic                   core_rst_n
);

	logic soft_rst;
	logic soft_rst_q;
	logic dl_q;
	logic ack_q;
	logic init_q;
	logic run_q;

	assign soft_rst = status[emu_cfg_pkg::ST_RESET];

	// Address and data go straight to the core
	assign ldr_addr   = ioctl_addr;
	assign ldr_wdat   = ioctl_dout;
	assign ldr_aen    = ioctl_download & ~ldr_done;
	// Host holds off while a byte is in flight
	assign ioctl_wait = ldr_wr;

	////////////////////////////////////////////////////////////////////////
	// Edge history and reset flags
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			soft_rst_q <= 1'b0;
			dl_q       <= 1'b0;
			ack_q      <= 1'b0;
			init_q     <= 1'b0;
			run_q      <= 1'b0;
			core_rst_n <= 1'b0;
		end else begin
			soft_rst_q <= soft_rst;
			dl_q       <= ioctl_download;
			ack_q      <= ldr_ack;
			// First release of the menu reset arms the core
			if (soft_rst_q && !soft_rst)
				init_q <= 1'b1;
			// First download start lets it run
			if (!dl_q && ioctl_download)
				run_q <= 1'b1;
			core_rst_n <= run_q & init_q & ~soft_rst & ~btn_reset;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Loader handshake
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ldr_wr   <= 1'b0;
			ldr_done <= 1'b0;
		end else begin
			// Ack rising edge retires the write
			if (!ack_q && ldr_ack && ldr_wr)
				ldr_wr <= 1'b0;
			if (ioctl_wr && !ldr_done)
				ldr_wr <= 1'b1;
			// Sticky until rst_n once the download ends
			if (dl_q && !ioctl_download)
				ldr_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/audio_mixer.sv
//////////////////////////////////////////////////////////////////////
// Stereo mixer: core audio plus synthesizer audio
// Synthesizer is muted when present but disabled
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  emu_cfg_pkg::status_t status,
	input  logic                 mt32_available,
	input  emu_av_pkg::sample_t  core_l,
	input  emu_av_pkg::sample_t  core_r,
	input  emu_av_pkg::sample_t  mt32_l,
	input  emu_av_pkg::sample_t  mt32_r,
	output emu_av_pkg::sample_t  audio_l,
	output emu_av_pkg::sample_t  audio_r
);

	logic                mute;
	emu_av_pkg::sample_t syn_l;
	emu_av_pkg::sample_t syn_r;

	assign mute  = mt32_available & status[emu_cfg_pkg::ST_MT32_DIS];
	assign syn_l = mute ? '0 : mt32_l;
	assign syn_r = mute ? '0 : mt32_r;

	// 16-bit sums, overflow wraps
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= core_l + syn_l;
			audio_r <= core_r + syn_r;
		end
	end

endmodule

`default_nettype wire

// File: rtl/mt32_display.sv
//////////////////////////////////////////////////////////////////////
// Synthesizer display logic: info request pulse,
// LCD on/off with auto timeout, LCD overlay on the video path
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "emu_defines.svh"

module mt32_display (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  emu_cfg_pkg::status_t status,
	input  logic                 mt32_newmode,
	input  logic                 lcd_en,
	input  logic                 lcd_update,
	input  logic                 lcd_pix,
	output logic                 mt32_info_req,
	output logic                 lcd_on,
	input  logic [7:0]           vid_in_r,
	input  logic [7:0]           vid_in_g,
	input  logic [7:0]           vid_in_b,
	input  logic                 vid_in_hs,
	input  logic                 vid_in_vs,
	input  logic                 vid_in_de,
	output logic [7:0]           vid_r,
	output logic [7:0]           vid_g,
	output logic [7:0]           vid_b,
	output logic                 vid_hs,
	output logic                 vid_vs,
	output logic                 vid_de
);

	localparam int HOLD_W = $clog2(`EMU_LCD_HOLD + 1);

	emu_cfg_pkg::info_mode_e info;
	emu_av_pkg::pixel_t      pix_q;
	logic                    mode_q;
	logic                    upd_q;
	logic [HOLD_W-1:0]       hold_q;
	logic                    overlay;
	logic [1:0]              pix2;

	assign info    = emu_cfg_pkg::info_mode_e'(status[emu_cfg_pkg::ST_INFO_LO +: 2]);
	assign overlay = lcd_on & lcd_en;
	assign pix2    = {2{lcd_pix}};

	////////////////////////////////////////////////////////////////////////
	// Info request and LCD state
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			mode_q        <= 1'b0;
			upd_q         <= 1'b0;
			hold_q        <= '0;
			lcd_on        <= 1'b0;
			mt32_info_req <= 1'b0;
		end else begin
			mode_q        <= mt32_newmode;
			upd_q         <= lcd_update;
			// Pulse on any mode toggle, menu mode only
			mt32_info_req <= (mode_q ^ mt32_newmode) && (info == emu_cfg_pkg::INFO_MENU);

			if (hold_q != '0)
				hold_q <= hold_q - 1'b1;

			if (info == emu_cfg_pkg::INFO_LCD_ON) begin
				lcd_on <= 1'b1;
			end else if (info != emu_cfg_pkg::INFO_LCD_AUTO) begin
				lcd_on <= 1'b0;
			end else begin
				// Auto mode, lit for a while after each update
				if (hold_q == '0)
					lcd_on <= 1'b0;
				if (upd_q ^ lcd_update) begin
					lcd_on <= 1'b1;
					hold_q <= HOLD_W'(`EMU_LCD_HOLD);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Video path, one register stage
	always_ff @(posedge clk_sys) begin
		if (overlay) begin
			// Two copies of the LCD bit over the top six bits
			pix_q.r <= {pix2, vid_in_r[7:2]};
			pix_q.g <= {pix2, vid_in_g[7:2]};
			pix_q.b <= {pix2, vid_in_b[7:2]};
		end else begin
			pix_q.r <= vid_in_r;
			pix_q.g <= vid_in_g;
			pix_q.b <= vid_in_b;
		end
	end

	// Sync and enable delayed alongside the pixel
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vid_hs <= 1'b0;
			vid_vs <= 1'b0;
			vid_de <= 1'b0;
		end else begin
			vid_hs <= vid_in_hs;
			vid_vs <= vid_in_vs;
			vid_de <= vid_in_de;
		end
	end

	assign vid_r = pix_q.r;
	assign vid_g = pix_q.g;
	assign vid_b = pix_q.b;

endmodule

`default_nettype wire

// File: rtl/emu_glue.sv
//////////////////////////////////////////////////////////////////////
// Top level of the emulator glue logic
// Status registers, reset and loader, audio mixer, LCD display
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "emu_defines.svh"

module emu_glue (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	// APB slave
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`EMU_APB_AW-1:0] paddr,
	input  logic [`EMU_APB_DW-1:0] pwdata,
	output logic [`EMU_APB_DW-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr,
	// Host download
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  logic [`EMU_LDR_AW-1:0] ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	output logic                   ioctl_wait,
	// Core loader
	output logic [`EMU_LDR_AW-1:0] ldr_addr,
	output logic [7:0]             ldr_wdat,
	output logic                   ldr_aen,
	output logic                   ldr_wr,
	input  logic                   ldr_ack,
	output logic                   ldr_done,
	// Core reset
	output logic                   core_rst_n,
	input  logic                   btn_reset,
	// Audio
	input  emu_av_pkg::sample_t    core_l,
	input  emu_av_pkg::sample_t    core_r,
	input  emu_av_pkg::sample_t    mt32_l,
	input  emu_av_pkg::sample_t    mt32_r,
	output emu_av_pkg::sample_t    audio_l,
	output emu_av_pkg::sample_t    audio_r,
	// Synthesizer status
	input  logic                   mt32_available,
	input  logic                   mt32_newmode,
	input  logic                   lcd_en,
	input  logic                   lcd_update,
	input  logic                   lcd_pix,
	output logic                   mt32_info_req,
	// Video
	input  logic [7:0]             vid_in_r,
	input  logic [7:0]             vid_in_g,
	input  logic [7:0]             vid_in_b,
	input  logic                   vid_in_hs,
	input  logic                   vid_in_vs,
	input  logic                   vid_in_de,
	output logic [7:0]             vid_r,
	output logic [7:0]             vid_g,
	output logic [7:0]             vid_b,
	output logic                   vid_hs,
	output logic                   vid_vs,
	output logic                   vid_de
);

	emu_cfg_pkg::status_t status;
	logic                 lcd_on;

	status_regs status_regs_i (
		.clk_sys, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		// Read-only bits fed back from the other blocks
		.sys_flags ({ldr_done, core_rst_n, lcd_on}),
		.status
	);

	sys_ctrl sys_ctrl_i (
		.clk_sys, .rst_n, .status, .btn_reset,
		.ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_dout, .ioctl_wait,
		.ldr_addr, .ldr_wdat, .ldr_aen, .ldr_wr, .ldr_ack, .ldr_done,
		.core_rst_n
	);

	audio_mixer audio_mixer_i (
		.clk_sys, .rst_n, .status, .mt32_available,
		.core_l, .core_r, .mt32_l, .mt32_r, .audio_l, .audio_r
	);

	mt32_display mt32_display_i (
		.clk_sys, .rst_n, .status,
		.mt32_newmode, .lcd_en, .lcd_update, .lcd_pix, .mt32_info_req, .lcd_on,
		.vid_in_r, .vid_in_g, .vid_in_b, .vid_in_hs, .vid_in_vs, .vid_in_de,
		.vid_r, .vid_g, .vid_b, .vid_hs, .vid_vs, .vid_de
	);

endmodule

`default_nettype wire

// File: testbench/tb_clkgen.sv
//////////////////////////////////////////////////////////////////////
// Clock and reset generator for the glue testbench
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter real PERIOD_NS  = 100.0,
	parameter int  RST_CYCLES = 8
) (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_sys = ~clk_sys;
	end

	// Reset released on a falling edge, away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/emu_chk.sv
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the reset sequencer and loader
// Bound into every sys_ctrl instance
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module emu_chk (
	input wire logic clk_sys,
	input wire logic rst_n,
	input wire logic soft_rst,
	input wire logic ldr_wr,
	input wire logic ldr_done,
	input wire logic core_rst_n
);

	// No new loader write once the download is over
	a_wr_after_done: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(ldr_wr) |-> !$past(ldr_done))
		else $error("ldr_wr rose while ldr_done was high");

	// Done is sticky
	a_done_sticky: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$fell(ldr_done))
		else $error("ldr_done fell while rst_n was high");

	// Menu reset holds the core in reset
	a_soft_rst: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$past(soft_rst) |-> !core_rst_n)
		else $error("core_rst_n high one edge after soft reset was set");

endmodule

bind sys_ctrl emu_chk chk_i (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.soft_rst   (status[emu_cfg_pkg::ST_RESET]),
	.ldr_wr     (ldr_wr),
	.ldr_done   (ldr_done),
	.core_rst_n (core_rst_n)
);

`default_nettype wire

// File: testbench/tb_emu.sv
//////////////////////////////////////////////////////////////////////
// Testbench top for the emulator glue logic
// APB, reset, loader, audio, LCD overlay and info request tests
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "emu_defines.svh"

module tb_emu;

	localparam int RST_CYCLES = 8;
	// Twice the rough sum of all test lengths
	localparam int WD_CYCLES  = 2 * (RST_CYCLES + 900 + 2 * `EMU_LCD_HOLD);

	logic clk_sys, rst_n;
	logic psel, penable, pwrite, pready, pslverr;
	logic [`EMU_APB_AW-1:0] paddr;
	logic [`EMU_APB_DW-1:0] pwdata, prdata;
	logic ioctl_download, ioctl_wr, ioctl_wait;
	logic [`EMU_LDR_AW-1:0] ioctl_addr, ldr_addr;
	logic [7:0] ioctl_dout, ldr_wdat;
	logic ldr_aen, ldr_wr, ldr_ack, ldr_done, core_rst_n, btn_reset;
	logic [15:0] core_l, core_r, mt32_l, mt32_r, audio_l, audio_r;
	logic mt32_available, mt32_newmode, lcd_en, lcd_update, lcd_pix, mt32_info_req;
	logic [7:0] vid_in_r, vid_in_g, vid_in_b, vid_r, vid_g, vid_b;
	logic vid_in_hs, vid_in_vs, vid_in_de, vid_hs, vid_vs, vid_de;

	int errors, tests, base_err, cyc;
	// Expected state that the tests keep in step with the DUT
	logic aud_en, vid_en, mute_exp, lcd_exp, aud_q, vid_q;
	logic [15:0] exp_l, exp_r;
	logic [7:0] exp_vr, exp_vg, exp_vb;
	logic [2:0] exp_sync;

	tb_clkgen #(.PERIOD_NS(100.0), .RST_CYCLES(RST_CYCLES)) clkgen_i (.clk_sys, .rst_n);

	emu_glue dut_i (.*);

	// Mixer rule with the synthesizer term dropped when muted
	function automatic logic [15:0] mix_ref(input logic [15:0] c, input logic [15:0] m,
		input logic mute);
		logic [16:0] s;
		s = {1'b0, c} + (mute ? 17'd0 : {1'b0, m});
		return s[15:0];
	endfunction

	// Overlay rule for one channel
	function automatic logic [7:0] pix_ref(input logic [7:0] ch, input logic pix,
		input logic ov);
		return ov ? {pix, pix, ch[7:2]} : ch;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%s: %0d errors", name, errors - base_err);
		base_err = errors;
	endtask

	////////////////////////////////////////////////////////////////////////
	// Expectation taken at the rising edge and checked at the next negedge
	always @(posedge clk_sys) begin
		cyc++;
		exp_l  = mix_ref(core_l, mt32_l, mute_exp);
		exp_r  = mix_ref(core_r, mt32_r, mute_exp);
		exp_vr = pix_ref(vid_in_r, lcd_pix, lcd_exp & lcd_en);
		exp_vg = pix_ref(vid_in_g, lcd_pix, lcd_exp & lcd_en);
		exp_vb = pix_ref(vid_in_b, lcd_pix, lcd_exp & lcd_en);
		exp_sync = {vid_in_hs, vid_in_vs, vid_in_de};
		aud_q  = aud_en;
		vid_q  = vid_en;
	end

	always @(negedge clk_sys) begin
		if (aud_q) begin
			check_val("audio_l", audio_l, exp_l);
			check_val("audio_r", audio_r, exp_r);
		end
		if (vid_q) begin
			check_val("vid_r", vid_r, exp_vr);
			check_val("vid_g", vid_g, exp_vg);
			check_val("vid_b", vid_b, exp_vb);
			check_val("vid_sync", {vid_hs, vid_vs, vid_de}, exp_sync);
		end
	end

	// One APB transfer through its setup and access phases
	task automatic apb_xfer(input logic [3:0] addr, input logic wr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waits;
		@(negedge clk_sys);
		psel    = 1'b1;
		penable = 1'b0;
		paddr   = addr;
		pwrite  = wr;
		pwdata  = wdata;
		@(negedge clk_sys);
		penable = 1'b1;
		waits = 0;
		do begin
			@(negedge clk_sys);
			waits++;
		end while (!pready && waits < 8);
		if (!pready) begin
			$display("APB access to offset %h never completed", addr);
			errors++;
		end else if (waits != 1) begin
			$display("APB access took %0d access cycles before pready", waits);
			errors++;
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clk_sys);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_xfer(addr, 1'b1, data, rd, err);
		check_val("pslverr", err, 0);
	endtask

	task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
		logic err;
		apb_xfer(addr, 1'b0, 0, data, err);
		check_val("pslverr", err, 0);
	endtask

	task automatic drive_random_av();
		{core_l, core_r, mt32_l, mt32_r} = {$urandom, $urandom};
		{vid_in_r, vid_in_g, vid_in_b} = $urandom;
		{vid_in_hs, vid_in_vs, vid_in_de, lcd_en, lcd_pix} = $urandom;
	endtask

	// Watchdog
	initial begin
		#(WD_CYCLES * 100);
		$display("Timeout after %0d cycles, run stopped", WD_CYCLES);
		$display("test failed");
		$finish;
	end

	initial begin
		logic [31:0] rd, lo, hi;
		logic err;
		int n, t0, pulses;
		void'($urandom(32'hdcb2));
		{psel, penable, pwrite, paddr, pwdata} = '0;
		{ioctl_download, ioctl_wr, ioctl_addr, ioctl_dout, ldr_ack, btn_reset} = '0;
		{core_l, core_r, mt32_l, mt32_r, mt32_available, mt32_newmode} = '0;
		{lcd_en, lcd_update, lcd_pix, vid_in_r, vid_in_g, vid_in_b} = '0;
		{vid_in_hs, vid_in_vs, vid_in_de} = '0;
		{errors, tests, base_err, cyc} = '0;
		{aud_en, vid_en, mute_exp, lcd_exp} = '0;
		@(posedge rst_n);

		// 1. APB readback, wait state and error responses
		for (int i = 0; i < 6; i++) begin
			lo = $urandom & ~32'h1;
			hi = $urandom;
			reg_write(`EMU_REG_STAT_LO, lo);
			reg_write(`EMU_REG_STAT_HI, hi);
			reg_read(`EMU_REG_STAT_LO, rd);
			check_val("stat_lo", rd, lo);
			reg_read(`EMU_REG_STAT_HI, rd);
			check_val("stat_hi", rd, hi);
		end
		apb_xfer(4'hc, 1'b0, 0, rd, err);
		check_val("pslverr_rd_c", err, 1);
		apb_xfer(4'hc, 1'b1, 32'hffff_ffff, rd, err);
		check_val("pslverr_wr_c", err, 1);
		apb_xfer(`EMU_REG_SYS, 1'b1, 32'hffff_ffff, rd, err);
		check_val("pslverr_wr_8", err, 1);
		reg_read(`EMU_REG_STAT_LO, rd);
		check_val("stat_lo", rd, lo);
		reg_read(`EMU_REG_STAT_HI, rd);
		check_val("stat_hi", rd, hi);
		reg_write(`EMU_REG_STAT_LO, 0);
		reg_write(`EMU_REG_STAT_HI, 0);
		end_test("apb");

		// 2. Reset sequence
		check_val("core_rst_n", core_rst_n, 0);
		reg_write(`EMU_REG_STAT_LO, 32'h1);
		reg_write(`EMU_REG_STAT_LO, 32'h0);
		repeat (3) @(negedge clk_sys);
		check_val("core_rst_n", core_rst_n, 0);
		ioctl_download = 1'b1;
		repeat (3) @(negedge clk_sys);
		check_val("core_rst_n", core_rst_n, 1);
		btn_reset = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_val("core_rst_n", core_rst_n, 0);
		btn_reset = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_val("core_rst_n", core_rst_n, 1);
		reg_write(`EMU_REG_STAT_LO, 32'h1);
		// Status bit lands on the completing edge, core reset one edge later
		@(negedge clk_sys);
		check_val("core_rst_n", core_rst_n, 0);
		reg_write(`EMU_REG_STAT_LO, 32'h0);
		repeat (2) @(negedge clk_sys);
		check_val("core_rst_n", core_rst_n, 1);
		end_test("reset");

		// 3. Loader handshake with delayed ack
		for (int i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			ioctl_addr = `EMU_LDR_AW'($urandom);
			ioctl_dout = 8'($urandom);
			ioctl_wr   = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			check_val("ldr_aen", ldr_aen, 1);
			check_val("ldr_addr", ldr_addr, ioctl_addr);
			check_val("ldr_wdat", ldr_wdat, ioctl_dout);
			n = 1 + ($urandom % 4);
			repeat (n) begin
				check_val("ldr_wr", ldr_wr, 1);
				check_val("ioctl_wait", ioctl_wait, 1);
				@(negedge clk_sys);
			end
			ldr_ack = 1'b1;
			n = 0;
			while (ioctl_wait && n < 10) begin
				@(negedge clk_sys);
				n++;
			end
			if (ioctl_wait) begin
				$display("ldr_wr did not drop after ldr_ack");
				errors++;
			end
			ldr_ack = 1'b0;
		end
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_val("ldr_done", ldr_done, 1);
		check_val("ldr_aen", ldr_aen, 0);
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		repeat (2) begin
			@(negedge clk_sys);
			check_val("ldr_wr", ldr_wr, 0);
		end
		end_test("loader");

		// 4. Audio sums and then the muted synthesizer
		aud_en = 1'b1;
		repeat (30) @(negedge clk_sys) drive_random_av();
		aud_en = 1'b0;
		reg_write(`EMU_REG_STAT_LO, 32'h1 << emu_cfg_pkg::ST_MT32_DIS);
		mt32_available = 1'b1;
		mute_exp = 1'b1;
		aud_en = 1'b1;
		repeat (30) @(negedge clk_sys) drive_random_av();
		aud_en = 1'b0;
		// Last pending sample is compared on this edge
		@(negedge clk_sys);
		end_test("audio");

		// 5. LCD overlay on and off and then the auto timeout
		reg_write(`EMU_REG_STAT_HI,
			32'(emu_cfg_pkg::INFO_LCD_ON) << (emu_cfg_pkg::ST_INFO_LO - 32));
		repeat (2) @(negedge clk_sys);
		lcd_exp = 1'b1;
		vid_en = 1'b1;
		repeat (30) @(negedge clk_sys) drive_random_av();
		vid_en = 1'b0;
		reg_write(`EMU_REG_STAT_HI, 32'(emu_cfg_pkg::INFO_OFF));
		repeat (2) @(negedge clk_sys);
		lcd_exp = 1'b0;
		vid_en = 1'b1;
		repeat (30) @(negedge clk_sys) drive_random_av();
		vid_en = 1'b0;
		reg_write(`EMU_REG_STAT_HI,
			32'(emu_cfg_pkg::INFO_LCD_AUTO) << (emu_cfg_pkg::ST_INFO_LO - 32));
		reg_read(`EMU_REG_SYS, rd);
		check_val("lcd_on", rd[0], 0);
		@(negedge clk_sys);
		lcd_update = ~lcd_update;
		t0 = cyc;
		reg_read(`EMU_REG_SYS, rd);
		check_val("lcd_on", rd[0], 1);
		while (rd[0] && cyc - t0 < 2 * `EMU_LCD_HOLD)
			reg_read(`EMU_REG_SYS, rd);
		if (rd[0] || cyc - t0 < `EMU_LCD_HOLD || cyc - t0 > `EMU_LCD_HOLD + 8) begin
			$display("LCD auto mode fell %0d cycles after update", cyc - t0);
			errors++;
		end
		end_test("lcd");

		// 6. Info request pulses in menu mode only
		for (int m = 0; m < 4; m++) begin
			reg_write(`EMU_REG_STAT_HI, 32'(m) << (emu_cfg_pkg::ST_INFO_LO - 32));
			@(negedge clk_sys);
			mt32_newmode = ~mt32_newmode;
			pulses = 0;
			repeat (5) begin
				@(negedge clk_sys);
				pulses += mt32_info_req;
			end
			check_val("mt32_info_req_count", pulses, (m == emu_cfg_pkg::INFO_MENU) ? 1 : 0);
		end
		end_test("info_req");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
rtl/emu_cfg_pkg.sv
rtl/emu_av_pkg.sv
rtl/status_regs.sv
rtl/sys_ctrl.sv
rtl/audio_mixer.sv
rtl/mt32_display.sv
rtl/emu_glue.sv
testbench/tb_clkgen.sv
testbench/emu_chk.sv
testbench/tb_emu.sv

// File: Bender.yml
package:
  name: emu_glue

export_include_dirs:
  - include

sources:
  - rtl/emu_cfg_pkg.sv
  - rtl/emu_av_pkg.sv
  - rtl/status_regs.sv
  - rtl/sys_ctrl.sv
  - rtl/audio_mixer.sv
  - rtl/mt32_display.sv
  - rtl/emu_glue.sv
  - target: test
    files:
      - testbench/tb_clkgen.sv
      - testbench/emu_chk.sv
      - testbench/tb_emu.sv
